//--- tb.f
hw/gpif_ingress_pkg.sv
hw/gpif_check_pkg.sv
hw/gpif_stream_fifo.sv
hw/gpif_packet_checker.sv
hw/gpif_packet_gate.sv
hw/gpif_word_packer.sv
hw/gpif_ingress_top.sv
tests/tb_gpif_ingress.sv

//--- Bender.yml
package:
  name: gpif_ingress

sources:
  # packages first, then leaf modules, then the top
  - hw/gpif_ingress_pkg.sv
  - hw/gpif_check_pkg.sv
  - hw/gpif_stream_fifo.sv
  - hw/gpif_packet_checker.sv
  - hw/gpif_packet_gate.sv
  - hw/gpif_word_packer.sv
  - hw/gpif_ingress_top.sv

  - target: test
    files:
      - tests/tb_gpif_ingress.sv

//--- tests/tb_gpif_ingress.sv
/*
 * testbench for the GPIF II ingress path, packets of 32-bit words in and 64-bit words out.
 * a monitor collects output beats and each directed test compares them with the packing rule.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_gpif_ingress;

   // about 3000 words in all, random ready and input gaps stretch that to a few cycles each
   localparam CYCLE_LIMIT = 20000;

   logic        gpif_clk;
   logic        i_rst_n;
   logic [31:0] i_in_tdata;
   logic        i_in_tlast;
   logic        i_in_tvalid;
   logic        o_in_tready;
   logic        o_fifo_has_space;
   logic        o_fifo_nearly_full;
   logic [63:0] o_out_tdata;
   logic        o_out_tlast;
   logic        o_out_tvalid;
   logic        i_out_tready;
   logic        o_bus_error;

   // scoreboard entries are {last, data}
   logic [64:0] exp_q[$];
   logic [64:0] got_q[$];
   // words of the packet being sent
   logic [31:0] pkt_q[$];
   int          errors;
   int          bus_err_cnt;
   int          bus_err_base;
   int          cycle_cnt;
   // 0 ready high, 1 random, 2 held low
   int          ready_mode;

   gpif_ingress_top UUT (
      .gpif_clk(gpif_clk), .i_rst_n(i_rst_n),
      .i_in_tdata(i_in_tdata), .i_in_tlast(i_in_tlast), .i_in_tvalid(i_in_tvalid),
      .o_in_tready(o_in_tready),
      .o_fifo_has_space(o_fifo_has_space), .o_fifo_nearly_full(o_fifo_nearly_full),
      .o_out_tdata(o_out_tdata), .o_out_tlast(o_out_tlast), .o_out_tvalid(o_out_tvalid),
      .i_out_tready(i_out_tready), .o_bus_error(o_bus_error)
   );

   initial begin
      gpif_clk = 1'b0;
      forever #10 gpif_clk = ~gpif_clk;
   end

   //////////////////////////////////////////////////
   // output side, ready driver and monitor
   //////////////////////////////////////////////////

   always @(negedge gpif_clk) begin
      case (ready_mode)
         0: i_out_tready = 1'b1;
         1: i_out_tready = ($urandom % 3) != 0;
         default: i_out_tready = 1'b0;
      endcase
      // outputs are registered, so this beat moves on the coming rising edge
      if (i_rst_n && o_out_tvalid && i_out_tready)
         got_q.push_back({o_out_tlast, o_out_tdata});
      if (i_rst_n && o_bus_error)
         bus_err_cnt++;
   end

   // cycle counter, ends a hung run
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge gpif_clk);
         cycle_cnt++;
      end
      $display("timeout: output did not complete within %0d cycles", CYCLE_LIMIT);
      errors++;
      print_counts();
      $display("RESULT: FAIL");
      $finish;
   end

   task automatic print_counts();
      $display("errors %0d, bus errors seen %0d", errors, bus_err_cnt);
   endtask

   task automatic compare_bit(input string what, input logic expected, input logic actual);
      assert (actual === expected) else begin
         $display("mismatch %s: expected %b actual %b", what, expected, actual);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // input side, called and left on a falling edge
   //////////////////////////////////////////////////

   task automatic send_word(input logic [31:0] data, input logic last);
      logic accepted;
      accepted = 1'b0;
      i_in_tdata  = data;
      i_in_tlast  = last;
      i_in_tvalid = 1'b1;
      // o_in_tready comes from a register, steady until the next rising edge
      while (!accepted) begin
         accepted = o_in_tready;
         @(negedge gpif_clk);
      end
      i_in_tvalid = 1'b0;
   endtask

   // pairs go low half first, an odd last word gets a zero high half
   function automatic void expect_packet();
      int   i;
      logic last;
      i = 0;
      while (i < pkt_q.size()) begin
         if (i + 1 < pkt_q.size()) begin
            last = (i + 2 == pkt_q.size());
            exp_q.push_back({last, pkt_q[i + 1], pkt_q[i]});
         end else begin
            exp_q.push_back({1'b1, 32'h0, pkt_q[i]});
         end
         i += 2;
      end
   endfunction

   // header carries len_field in its low half, last goes on word n_words
   task automatic send_packet(input int len_field, input int n_words, input bit good,
                              input bit gaps);
      logic [31:0] w;
      int          i;
      int          n_gap;
      pkt_q.delete();
      for (i = 0; i < n_words; i++) begin
         w = $urandom;
         if (i == 0)
            w[15:0] = len_field[15:0];
         pkt_q.push_back(w);
      end
      if (good)
         expect_packet();
      for (i = 0; i < n_words; i++) begin
         n_gap = 0;
         if (gaps && ($urandom % 4) == 0)
            n_gap = 1 + $urandom % 3;
         repeat (n_gap) @(negedge gpif_clk);
         send_word(pkt_q[i], i == n_words - 1);
      end
   endtask

   // waits for every expected beat, the cycle counter bounds the wait
   task automatic compare_output(input string name, input int bus_errs);
      logic [64:0] e;
      logic [64:0] g;
      int          n;
      n = 0;
      while (got_q.size() < exp_q.size())
         @(negedge gpif_clk);
      while (exp_q.size() > 0) begin
         e = exp_q.pop_front();
         g = got_q.pop_front();
         assert (g === e) else begin
            $display("mismatch %s beat %0d: expected %h actual %h", name, n, e, g);
            errors++;
         end
         n++;
      end
      assert (got_q.size() == 0) else begin
         $display("%s: output carried %0d words more than were sent", name, got_q.size());
         errors++;
      end
      assert (bus_err_cnt - bus_err_base == bus_errs) else begin
         $display("mismatch %s bus error pulses: expected %0d actual %0d", name, bus_errs,
                  bus_err_cnt - bus_err_base);
         errors++;
      end
      got_q.delete();
      bus_err_base = bus_err_cnt;
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic check_reset_state();
      compare_bit("reset_state o_out_tvalid", 1'b0, o_out_tvalid);
      compare_bit("reset_state o_bus_error", 1'b0, o_bus_error);
      compare_bit("reset_state o_in_tready", 1'b1, o_in_tready);
      compare_bit("reset_state o_fifo_has_space", 1'b1, o_fifo_has_space);
      compare_bit("reset_state o_fifo_nearly_full", 1'b0, o_fifo_nearly_full);
   endtask

   task automatic send_even_packets();
      send_packet(2, 2, 1, 0);
      send_packet(4, 4, 1, 0);
      send_packet(8, 8, 1, 0);
      send_packet(16, 16, 1, 0);
      send_packet(64, 64, 1, 0);
      compare_output("even_packets", 0);
   endtask

   task automatic send_odd_packets();
      send_packet(3, 3, 1, 0);
      send_packet(5, 5, 1, 0);
      send_packet(17, 17, 1, 0);
      send_packet(255, 255, 1, 0);
      compare_output("odd_packets", 0);
   endtask

   // each bad packet sits between good ones
   task automatic send_bad_packets();
      send_packet(6, 6, 1, 0);
      // last flag on word 4 of 10
      send_packet(10, 4, 0, 0);
      send_packet(7, 7, 1, 0);
      send_packet(gpif_check_pkg::MAX_PKT_WORDS + 44, 5, 0, 0);
      send_packet(4, 4, 1, 0);
      // length 4 but the last flag only comes on word 7
      send_packet(4, 7, 0, 0);
      send_packet(9, 9, 1, 0);
      compare_output("bad_packets", 3);
   endtask

   // random lengths, the header always matches the wire length
   task automatic stress_back_pressure();
      int k;
      int n;
      ready_mode = 1;
      for (k = 0; k < 20; k++) begin
         n = gpif_check_pkg::MIN_PKT_WORDS + $urandom % 127;
         send_packet(n, n, 1, 1);
      end
      compare_output("back_pressure", 0);
      ready_mode = 0;
   endtask

   // stall the output until the input side gives up, then drain everything
   task automatic exercise_flags();
      int t_space;
      int t_full;
      int t_stop;
      int k;
      t_space = -1;
      t_full  = -1;
      t_stop  = -1;
      ready_mode = 2;
      fork
         for (k = 0; k < 5; k++)
            send_packet(gpif_check_pkg::MAX_PKT_WORDS, gpif_check_pkg::MAX_PKT_WORDS, 1, 0);
         begin
            while (t_stop < 0) begin
               @(negedge gpif_clk);
               if (t_space < 0 && !o_fifo_has_space)
                  t_space = cycle_cnt;
               if (t_full < 0 && o_fifo_nearly_full)
                  t_full = cycle_cnt;
               if (!o_in_tready)
                  t_stop = cycle_cnt;
            end
            ready_mode = 0;
         end
      join
      assert (t_space >= 0 && t_space < t_full) else begin
         $display("flags: has_space did not fall before nearly_full rose");
         errors++;
      end
      assert (t_full >= 0 && t_full < t_stop) else begin
         $display("flags: nearly_full did not rise before o_in_tready dropped");
         errors++;
      end
      compare_output("flags", 0);
      compare_bit("flags o_fifo_has_space after drain", 1'b1, o_fifo_has_space);
      compare_bit("flags o_fifo_nearly_full after drain", 1'b0, o_fifo_nearly_full);
      compare_bit("flags o_in_tready after drain", 1'b1, o_in_tready);
   endtask

   initial begin
      i_rst_n      = 1'b0;
      i_in_tdata   = '0;
      i_in_tlast   = 1'b0;
      i_in_tvalid  = 1'b0;
      i_out_tready = 1'b1;
      ready_mode   = 0;
      errors       = 0;
      bus_err_cnt  = 0;
      bus_err_base = 0;
      void'($urandom(32'h30ab));
      repeat (8) @(negedge gpif_clk);
      i_rst_n = 1'b1;
      @(negedge gpif_clk);
      check_reset_state();
      send_even_packets();
      send_odd_packets();
      send_bad_packets();
      stress_back_pressure();
      exercise_flags();
      print_counts();
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/gpif_ingress_top.sv
/*
 * receive path of the USB 3 bridge, GPIF II words in and 64-bit packets out.
 * burst buffer space drives the has-space and nearly-full flags to the GPIF II master.
 */
`timescale 1ns/10ps
`default_nettype none

module gpif_ingress_top (
   input  wire                                 gpif_clk,
   input  wire                                 i_rst_n,
   input  wire  [gpif_ingress_pkg::WORD_W-1:0] i_in_tdata,
   input  wire                                 i_in_tlast,
   input  wire                                 i_in_tvalid,
   output logic                                o_in_tready,
   output logic                                o_fifo_has_space,
   output logic                                o_fifo_nearly_full,
   output logic [gpif_ingress_pkg::BUS_W-1:0]  o_out_tdata,
   output logic                                o_out_tlast,
   output logic                                o_out_tvalid,
   input  wire                                 i_out_tready,
   output logic                                o_bus_error
);

   // timing stage to burst buffer
   logic [gpif_ingress_pkg::WORD_W-1:0]  t_tdata;
   logic                                 t_tlast;
   logic                                 t_tvalid;
   logic                                 t_tready;
   // burst buffer to checker
   logic [gpif_ingress_pkg::WORD_W-1:0]  b_tdata;
   logic                                 b_tlast;
   logic                                 b_tvalid;
   logic                                 b_tready;
   logic [gpif_ingress_pkg::SPACE_W-1:0] burst_space;
   // checker to gate strobes
   logic                                 wr_en;
   logic [gpif_ingress_pkg::WORD_W-1:0]  wr_data;
   logic                                 wr_last;
   gpif_check_pkg::gate_cmd_e            gate_cmd;
   logic                                 gate_full;
   // gate to packer
   logic [gpif_ingress_pkg::WORD_W-1:0]  g_tdata;
   logic                                 g_tlast;
   logic                                 g_tvalid;
   logic                                 g_tready;

   //////////////////////////////////////////////////
   // flags to the GPIF II master
   //////////////////////////////////////////////////

   // room for a full FX3 burst
   assign o_fifo_has_space = burst_space >=
      (gpif_ingress_pkg::SPACE_W'(1) << gpif_ingress_pkg::BURST_LOG2);
   assign o_fifo_nearly_full = burst_space <
      gpif_ingress_pkg::SPACE_W'(gpif_ingress_pkg::NEARLY_FULL_SPACE);

   // register stage right behind the pins
   gpif_stream_fifo #(.SIZE(gpif_ingress_pkg::TIMING_FIFO_SIZE)) u_timing_fifo (
      .gpif_clk(gpif_clk), .i_rst_n(i_rst_n),
      .i_tdata(i_in_tdata), .i_tlast(i_in_tlast), .i_tvalid(i_in_tvalid),
      .o_tready(o_in_tready),
      .o_tdata(t_tdata), .o_tlast(t_tlast), .o_tvalid(t_tvalid), .i_tready(t_tready),
      .o_space()
   );

   // takes a whole burst, its fill level sets the flags
   gpif_stream_fifo #(.SIZE(gpif_ingress_pkg::INGRESS_FIFO_SIZE)) u_burst_fifo (
      .gpif_clk(gpif_clk), .i_rst_n(i_rst_n),
      .i_tdata(t_tdata), .i_tlast(t_tlast), .i_tvalid(t_tvalid), .o_tready(t_tready),
      .o_tdata(b_tdata), .o_tlast(b_tlast), .o_tvalid(b_tvalid), .i_tready(b_tready),
      .o_space(burst_space)
   );

   gpif_packet_checker u_checker (
      .gpif_clk(gpif_clk), .i_rst_n(i_rst_n),
      .i_tdata(b_tdata), .i_tlast(b_tlast), .i_tvalid(b_tvalid), .o_tready(b_tready),
      .i_gate_full(gate_full),
      .o_wr_en(wr_en), .o_wr_data(wr_data), .o_wr_last(wr_last), .o_cmd(gate_cmd),
      .o_bus_error(o_bus_error)
   );

   gpif_packet_gate u_gate (
      .gpif_clk(gpif_clk), .i_rst_n(i_rst_n),
      .i_wr_en(wr_en), .i_wr_data(wr_data), .i_wr_last(wr_last), .i_cmd(gate_cmd),
      .o_full(gate_full),
      .o_tdata(g_tdata), .o_tlast(g_tlast), .o_tvalid(g_tvalid), .i_tready(g_tready)
   );

   // 32 to 64 bit conversion drives the host side
   gpif_word_packer u_packer (
      .gpif_clk(gpif_clk), .i_rst_n(i_rst_n),
      .i_tdata(g_tdata), .i_tlast(g_tlast), .i_tvalid(g_tvalid), .o_tready(g_tready),
      .o_tdata(o_out_tdata), .o_tlast(o_out_tlast), .o_tvalid(o_out_tvalid),
      .i_tready(i_out_tready)
   );

endmodule

`default_nettype wire

//--- hw/gpif_word_packer.sv
/*
 * packs pairs of 32-bit words into 64-bit host words, low half first.
 * an odd last word goes out alone with a zero high half.
 */
`timescale 1ns/10ps
`default_nettype none

module gpif_word_packer (
   input  wire                                 gpif_clk,
   input  wire                                 i_rst_n,
   input  wire  [gpif_ingress_pkg::WORD_W-1:0] i_tdata,
   input  wire                                 i_tlast,
   input  wire                                 i_tvalid,
   output logic                                o_tready,
   output logic [gpif_ingress_pkg::BUS_W-1:0]  o_tdata,
   output logic                                o_tlast,
   output logic                                o_tvalid,
   input  wire                                  i_tready
);

   // first word of a pair waits here
   logic [gpif_ingress_pkg::WORD_W-1:0] lo_word;
   // high when the next word fills the high half
   logic                                hi_sel;
   logic                                accept;
   // a beat leaves the output register on this accept
   logic                                emit;

   // take a word when the output register is empty or draining
   assign o_tready = !o_tvalid || i_tready;
   assign accept   = i_tvalid && o_tready;
   assign emit     = accept && (hi_sel || i_tlast);

   // control, output valid and half select
   always_ff @(posedge gpif_clk) begin
      if (!i_rst_n) begin
         hi_sel   <= 1'b0;
         o_tvalid <= 1'b0;
      end else begin
         if (emit)
            o_tvalid <= 1'b1;
         else if (i_tready)
            o_tvalid <= 1'b0;

         // back to the low half at every beat and packet end
         if (accept)
            hi_sel <= !hi_sel && !i_tlast;
      end
   end

   // payload
   always_ff @(posedge gpif_clk) begin
      if (accept && !hi_sel)
         lo_word <= i_tdata;
      if (emit) begin
         o_tlast <= i_tlast;
         if (hi_sel)
            o_tdata <= {i_tdata, lo_word};
         else
            o_tdata <= {{(gpif_ingress_pkg::BUS_W - gpif_ingress_pkg::WORD_W){1'b0}}, i_tdata};
      end
   end

endmodule

`default_nettype wire

//--- hw/gpif_packet_gate.sv
/*
 * holds each packet until the checker commits it, then streams it out.
 * a drop rewinds the write side so the packet is never seen at the output.
 */
`timescale 1ns/10ps
`default_nettype none

module gpif_packet_gate (
   input  wire                                 gpif_clk,
   input  wire                                 i_rst_n,
   input  wire                                 i_wr_en,
   input  wire  [gpif_ingress_pkg::WORD_W-1:0] i_wr_data,
   input  wire                                 i_wr_last,
   input  wire  gpif_check_pkg::gate_cmd_e     i_cmd,
   output logic                                o_full,
   output logic [gpif_ingress_pkg::WORD_W-1:0] o_tdata,
   output logic                                o_tlast,
   output logic                                o_tvalid,
   input  wire                                 i_tready
);

   // storage holds {last, data}
   logic [gpif_ingress_pkg::WORD_W:0]       mem [1 << gpif_check_pkg::GATE_SIZE];
   logic [gpif_check_pkg::GATE_SIZE-1:0]    wr_ptr;
   // first slot of the packet still being written
   logic [gpif_check_pkg::GATE_SIZE-1:0]    start_ptr;
   logic [gpif_check_pkg::GATE_SIZE-1:0]    rd_ptr;
   logic [gpif_check_pkg::GATE_SIZE-1:0]    wr_ptr_inc;
   logic                                    commit;
   logic                                    drop;
   logic                                    pop;

   assign commit     = (i_cmd == gpif_check_pkg::GATE_COMMIT);
   assign drop       = (i_cmd == gpif_check_pkg::GATE_DROP);
   assign wr_ptr_inc = wr_ptr + 1'b1;

   // one slot is kept empty so full and empty differ
   assign o_full = (wr_ptr_inc == rd_ptr);

   // only committed words, those before start_ptr, are readable
   assign o_tvalid = (rd_ptr != start_ptr);
   assign pop      = o_tvalid && i_tready;
   assign {o_tlast, o_tdata} = mem[rd_ptr];

   //////////////////////////////////////////////////
   // pointer control
   //////////////////////////////////////////////////

   always_ff @(posedge gpif_clk) begin
      if (!i_rst_n) begin
         wr_ptr    <= '0;
         start_ptr <= '0;
         rd_ptr    <= '0;
      end else begin
         if (drop) begin
            // forget the partial packet
            wr_ptr <= start_ptr;
         end else if (i_wr_en) begin
            wr_ptr <= wr_ptr_inc;
         end

         // commit covers the word written in the same cycle
         if (commit)
            start_ptr <= i_wr_en ? wr_ptr_inc : wr_ptr;

         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // payload array, a dropping write is not stored
   always_ff @(posedge gpif_clk) begin
      if (i_wr_en && !drop)
         mem[wr_ptr] <= {i_wr_last, i_wr_data};
   end

endmodule

`default_nettype wire

//--- hw/gpif_packet_checker.sv
/*
 * pops words from the burst buffer, checks each header length against the wire
 * length and tells the packet gate to keep or discard the packet.
 */
`timescale 1ns/10ps
`default_nettype none

module gpif_packet_checker (
   input  wire                                 gpif_clk,
   input  wire                                 i_rst_n,
   input  wire  [gpif_ingress_pkg::WORD_W-1:0] i_tdata,
   input  wire                                 i_tlast,
   input  wire                                 i_tvalid,
   output logic                                o_tready,
   input  wire                                 i_gate_full,
   output logic                                o_wr_en,
   output logic [gpif_ingress_pkg::WORD_W-1:0] o_wr_data,
   output logic                                o_wr_last,
   output gpif_check_pkg::gate_cmd_e           o_cmd,
   output logic                                o_bus_error
);

   gpif_check_pkg::chk_state_e          state;
   gpif_check_pkg::chk_state_e          state_nxt;
   logic                                pop;
   logic [gpif_check_pkg::LEN_W-1:0]    hdr_len;
   logic [gpif_check_pkg::LEN_W-1:0]    pkt_len;
   logic [gpif_check_pkg::LEN_W-1:0]    word_cnt;
   logic [gpif_check_pkg::LEN_W-1:0]    next_cnt;
   logic                                len_ok;
   logic                                drop;

   // pop whenever the gate can take a word, also in drain
   assign o_tready  = !i_gate_full;
   assign pop       = i_tvalid && !i_gate_full;
   assign o_wr_data = i_tdata;
   assign o_wr_last = i_tlast;

   // header length field and its range check
   assign hdr_len  = i_tdata[gpif_check_pkg::LEN_LSB +: gpif_check_pkg::LEN_W];
   assign len_ok   = (hdr_len >= gpif_check_pkg::LEN_W'(gpif_check_pkg::MIN_PKT_WORDS)) &&
                     (hdr_len <= gpif_check_pkg::LEN_W'(gpif_check_pkg::MAX_PKT_WORDS));
   // number of the word now on the input
   assign next_cnt = word_cnt + 1'b1;

   //////////////////////////////////////////////////
   // decision logic, gate strobes in the pop cycle
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      o_wr_en   = 1'b0;
      o_cmd     = gpif_check_pkg::GATE_NONE;
      if (pop) begin
         case (state)
            gpif_check_pkg::CHK_HEADER: begin
               o_wr_en = 1'b1;
               if (i_tlast) begin
                  // a one word packet is always short
                  o_cmd = gpif_check_pkg::GATE_DROP;
               end else if (!len_ok) begin
                  // drop now, the rest goes to drain
                  o_cmd     = gpif_check_pkg::GATE_DROP;
                  state_nxt = gpif_check_pkg::CHK_DRAIN;
               end else begin
                  state_nxt = gpif_check_pkg::CHK_BODY;
               end
            end
            gpif_check_pkg::CHK_BODY: begin
               o_wr_en = 1'b1;
               if (i_tlast) begin
                  // last on word number length is the only good ending
                  o_cmd = (next_cnt == pkt_len) ? gpif_check_pkg::GATE_COMMIT :
                                                  gpif_check_pkg::GATE_DROP;
                  state_nxt = gpif_check_pkg::CHK_HEADER;
               end else if (next_cnt == pkt_len) begin
                  // length reached without last, overrun
                  o_cmd     = gpif_check_pkg::GATE_DROP;
                  state_nxt = gpif_check_pkg::CHK_DRAIN;
               end
            end
            gpif_check_pkg::CHK_DRAIN: begin
               // words are popped but never written
               if (i_tlast)
                  state_nxt = gpif_check_pkg::CHK_HEADER;
            end
            default: state_nxt = gpif_check_pkg::CHK_HEADER;
         endcase
      end
   end

   // one drop per bad packet, so one error pulse each
   assign drop = (o_cmd == gpif_check_pkg::GATE_DROP);

   always_ff @(posedge gpif_clk) begin
      if (!i_rst_n) begin
         state       <= gpif_check_pkg::CHK_HEADER;
         o_bus_error <= 1'b0;
      end else begin
         state       <= state_nxt;
         o_bus_error <= drop;
      end
   end

   // length latch and word counter
   always_ff @(posedge gpif_clk) begin
      if (pop && state == gpif_check_pkg::CHK_HEADER) begin
         pkt_len  <= hdr_len;
         word_cnt <= gpif_check_pkg::LEN_W'(1);
      end else if (pop && state == gpif_check_pkg::CHK_BODY) begin
         word_cnt <= next_cnt;
      end
   end

endmodule

`default_nettype wire

//--- hw/gpif_stream_fifo.sv
/*
 * synchronous valid/ready FIFO carrying a word and its last flag.
 * serves as the pin timing stage and as the burst buffer, o_space feeds the flags.
 */
`timescale 1ns/10ps
`default_nettype none

module gpif_stream_fifo #(
   parameter SIZE = 9
) (
   input  wire                                  gpif_clk,
   input  wire                                  i_rst_n,
   input  wire  [gpif_ingress_pkg::WORD_W-1:0]  i_tdata,
   input  wire                                  i_tlast,
   input  wire                                  i_tvalid,
   output logic                                 o_tready,
   output logic [gpif_ingress_pkg::WORD_W-1:0]  o_tdata,
   output logic                                 o_tlast,
   output logic                                 o_tvalid,
   input  wire                                  i_tready,
   output logic [gpif_ingress_pkg::SPACE_W-1:0] o_space
);

   // storage holds {last, data}
   logic [gpif_ingress_pkg::WORD_W:0] mem [1 << SIZE];
   logic [SIZE-1:0]                   wr_ptr;
   logic [SIZE-1:0]                   rd_ptr;
   // fill count needs one more bit than the pointers
   logic [SIZE:0]                     fill;
   logic [SIZE:0]                     free;
   logic                              push;
   logic                              pop;

   // msb of fill is only set when every slot is taken
   assign o_tready = !fill[SIZE];
   assign o_tvalid = (fill != '0);
   assign push     = i_tvalid && o_tready;
   assign pop      = o_tvalid && i_tready;

   // read side straight from the array, a word written is seen next cycle
   assign {o_tlast, o_tdata} = mem[rd_ptr];

   // depth minus fill, zero extended to the space width
   assign free    = {1'b1, {SIZE{1'b0}}} - fill;
   assign o_space = {{(gpif_ingress_pkg::SPACE_W - SIZE - 1){1'b0}}, free};

   //////////////////////////////////////////////////
   // pointers and fill count
   //////////////////////////////////////////////////

   always_ff @(posedge gpif_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         // pointers wrap on their own, depth is a power of two
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            fill <= fill + 1'b1;
         else if (pop && !push)
            fill <= fill - 1'b1;
      end
   end

   // payload array
   always_ff @(posedge gpif_clk) begin
      if (push)
         mem[wr_ptr] <= {i_tlast, i_tdata};
   end

endmodule

`default_nettype wire

//--- hw/gpif_check_pkg.sv
/*
 * packet header layout, length limits and the checker and gate encodings.
 */
`default_nettype none

package gpif_check_pkg;

   // length field of the header word, in 32-bit words, header included
   localparam LEN_LSB = 0;
   localparam LEN_W = 16;

   // legal range of the length field
   localparam MIN_PKT_WORDS = 2;
   localparam MAX_PKT_WORDS = 256;

   // gate buffer, 512 words, room for more than one max packet
   localparam GATE_SIZE = 9;

   // checker FSM
   typedef enum logic [1:0] {
      CHK_HEADER,  // waiting for a header word
      CHK_BODY,    // counting the words of a packet
      CHK_DRAIN    // throwing away an overrun until its last word
   } chk_state_e;

   // strobes from checker to gate, valid alongside a write
   typedef enum logic [1:0] {
      GATE_NONE,
      GATE_COMMIT,
      GATE_DROP
   } gate_cmd_e;

endpackage

`default_nettype wire

//--- hw/gpif_ingress_pkg.sv
/*
 * stream widths, buffer depths and flag thresholds of the GPIF II ingress path.
 * referenced by scoped name from the FIFO, checker, gate, packer and top.
 */
`default_nettype none

package gpif_ingress_pkg;

   //////////////////////////////////////////////////
   // stream widths
   //////////////////////////////////////////////////

   // word width on the GPIF II pins
   localparam WORD_W = 32;
   // host side bus width, two GPIF words per beat
   localparam BUS_W = 64;

   //////////////////////////////////////////////////
   // buffer depths, all log2
   //////////////////////////////////////////////////

   // burst buffer, 512 words
   localparam INGRESS_FIFO_SIZE = 9;
   // timing stage behind the pins, 2 words
   localparam TIMING_FIFO_SIZE = 1;
   // largest FX3 burst, never more than the burst buffer holds
   localparam BURST_LOG2 = (INGRESS_FIFO_SIZE < 8) ? INGRESS_FIFO_SIZE : 8;

   //////////////////////////////////////////////////
   // flag thresholds
   //////////////////////////////////////////////////

   // nearly full once fewer than this many slots are free
   localparam NEARLY_FULL_SPACE = 6;
   // width of the free-space count
   localparam SPACE_W = 16;

endpackage

`default_nettype wire
